// ==== common/la_pkg.sv ====
// Shared definitions for the logic analyzer.
// Sample, bus and timestamp widths, the register map and the acquisition
// state encoding. Modules pull these in with a wildcard import.

package la_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // one sample, also trigger value and mask width
  typedef logic [7:0]  sample_t;
  // system bus byte address and data word
  typedef logic [6:0]  bus_addr_t;
  typedef logic [31:0] bus_data_t;
  // event timestamp
  typedef logic [63:0] stamp_t;
  // default views of the window and decimation counters
  typedef logic [16:0] count_t;
  typedef logic [16:0] dec_t;

  // acquisition FSM
  typedef enum logic [1:0] {
    IDLE,
    PRE,
    ARMED,
    POST
  } acq_state_t;

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////

  localparam bus_addr_t REG_CTL     = 7'h00;
  localparam bus_addr_t REG_CFG     = 7'h04;
  localparam bus_addr_t REG_TRG_SEL = 7'h08;
  localparam bus_addr_t REG_PRE     = 7'h10;
  localparam bus_addr_t REG_PST     = 7'h14;
  localparam bus_addr_t REG_STS_PRE = 7'h18;
  localparam bus_addr_t REG_STS_PST = 7'h1C;
  // timestamps, low word first
  localparam bus_addr_t REG_ACQ_LO  = 7'h20;
  localparam bus_addr_t REG_ACQ_HI  = 7'h24;
  localparam bus_addr_t REG_TRG_LO  = 7'h28;
  localparam bus_addr_t REG_TRG_HI  = 7'h2C;
  localparam bus_addr_t REG_STP_LO  = 7'h30;
  localparam bus_addr_t REG_STP_HI  = 7'h34;
  // pattern trigger
  localparam bus_addr_t REG_OLD_VAL = 7'h40;
  localparam bus_addr_t REG_OLD_MSK = 7'h44;
  localparam bus_addr_t REG_CUR_VAL = 7'h48;
  localparam bus_addr_t REG_CUR_MSK = 7'h4C;
  // decimation factor
  localparam bus_addr_t REG_DEC     = 7'h50;

  // control register bit positions
  localparam int CTL_RST = 0;
  localparam int CTL_ACQ = 1;
  localparam int CTL_STP = 2;
  localparam int CTL_SWT = 3;

endpackage

// ==== logic/la_decimator.sv ====
// Sample stream decimator.
// Keeps one valid sample out of every cfg_dec+1 and forwards it with a
// registered strobe one cycle later.

`timescale 1ns/1ps

module la_decimator import la_pkg::*; #(
  parameter int unsigned DCW = $bits(dec_t)
) (
  input  logic           bus,
  input  logic           reset,
  input  logic           ctl_rst,
  input  logic [DCW-1:0] cfg_dec,
  // input stream
  input  sample_t        sti_dat,
  input  logic           sti_vld,
  // decimated stream
  output sample_t        std_dat,
  output logic           std_vld
);

  // input valids seen since last kept sample
  logic [DCW-1:0] cnt;
  logic           keep;

  // >= so a factor lowered mid-count still wraps
  assign keep = sti_vld && (cnt >= cfg_dec);

  always_ff @(posedge bus) begin
    if (reset || ctl_rst) begin
      cnt     <= '0;
      std_vld <= 1'b0;
    end else begin
      std_vld <= keep;
      if (keep) begin
        cnt <= '0;
      end else if (sti_vld) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // payload follows the kept strobe
  always_ff @(posedge bus) begin
    if (keep) begin
      std_dat <= sti_dat;
    end
  end

endmodule

// ==== logic/la_trigger.sv ====
// Pattern trigger on the decimated stream.
// Compares the previous and the current kept sample against their own
// value under their own mask and pulses trg_out when both match.

`timescale 1ns/1ps

module la_trigger import la_pkg::*; (
  input  logic    bus,
  input  logic    reset,
  input  logic    ctl_rst,
  input  sample_t cfg_old_val,
  input  sample_t cfg_old_msk,
  input  sample_t cfg_cur_val,
  input  sample_t cfg_cur_msk,
  input  sample_t std_dat,
  input  logic    std_vld,
  output logic    trg_out
);

  // previous kept sample, zero after reset
  sample_t old_dat;
  logic    old_hit;
  logic    cur_hit;

  assign old_hit = (old_dat & cfg_old_msk) == (cfg_old_val & cfg_old_msk);
  assign cur_hit = (std_dat & cfg_cur_msk) == (cfg_cur_val & cfg_cur_msk);

  always_ff @(posedge bus) begin
    if (reset || ctl_rst) begin
      old_dat <= '0;
      trg_out <= 1'b0;
    end else begin
      // single-cycle pulse per matching kept sample
      trg_out <= std_vld & old_hit & cur_hit;
      if (std_vld) begin
        old_dat <= std_dat;
      end
    end
  end

endmodule

// ==== acquire/la_acq_counter.sv ====
// Timestamp and window counters for the acquisition block.
// The timestamp runs from reset on every cycle. The pre and post counters
// advance on the increment strobes and clear on clr or the control reset.

`timescale 1ns/1ps

module la_acq_counter import la_pkg::*; #(
  parameter int unsigned CW = $bits(count_t)
) (
  input  logic          bus,
  input  logic          reset,
  input  logic          ctl_rst,
  // clear both windows on acquire
  input  logic          clr,
  input  logic          pre_inc,
  input  logic          pst_inc,
  output stamp_t        cts,
  output logic [CW-1:0] sts_pre,
  output logic [CW-1:0] sts_pst
);

  //////////////////////////////////////////////////////////////////////
  // free-running timestamp
  //////////////////////////////////////////////////////////////////////

  // one tick per bus clock
  always_ff @(posedge bus) begin
    if (reset) begin
      cts <= '0;
    end else begin
      cts <= cts + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // window counters
  //////////////////////////////////////////////////////////////////////

  // saturation is handled by the FSM
  always_ff @(posedge bus) begin
    if (reset || ctl_rst || clr) begin
      sts_pre <= '0;
      sts_pst <= '0;
    end else begin
      if (pre_inc) begin
        sts_pre <= sts_pre + 1'b1;
      end
      if (pst_inc) begin
        sts_pst <= sts_pst + 1'b1;
      end
    end
  end

endmodule

// ==== acquire/la_acq_fsm.sv ====
// Acquisition state machine.
// Fills the pre-trigger window, waits for a trigger, passes the post-trigger
// window to the output stream and latches acquire, trigger and stop times.

`timescale 1ns/1ps

module la_acq_fsm import la_pkg::*; #(
  parameter int unsigned CW = $bits(count_t)
) (
  input  logic          bus,
  input  logic          reset,
  // control strobes
  input  logic          ctl_rst,
  input  logic          ctl_acq,
  input  logic          ctl_stp,
  input  logic          ctl_trg,
  // configuration
  input  logic          cfg_con,
  input  logic [CW-1:0] cfg_pre,
  input  logic [CW-1:0] cfg_pst,
  // streams
  input  sample_t       std_dat,
  input  logic          std_vld,
  output sample_t       sto_dat,
  output logic          sto_vld,
  // status and timestamps
  output logic          sts_acq,
  output logic          sts_trg,
  output logic [CW-1:0] sts_pre,
  output logic [CW-1:0] sts_pst,
  output stamp_t        cts_acq,
  output stamp_t        cts_trg,
  output stamp_t        cts_stp
);

  acq_state_t state;
  stamp_t     cts;
  logic       acq_start;
  logic       trg_hit;
  logic       pre_inc;
  logic       pst_inc;
  logic       pst_end;
  logic       stp_hit;

  ////////////////////////////////////////////////////////////////////
  // event decode
  ////////////////////////////////////////////////////////////////////

  assign sts_acq   = (state != IDLE);
  assign acq_start = ctl_acq && (state == IDLE);
  // triggers outside ARMED are dropped
  assign trg_hit   = ctl_trg && (state == ARMED);

  // both counters saturate at their window size
  assign pre_inc = std_vld && (state == PRE) && (sts_pre != cfg_pre);
  assign pst_inc = std_vld && (state == POST) && (sts_pst != cfg_pst);
  // window full including the sample counted this cycle
  assign pst_end = (sts_pst + CW'(pst_inc)) == cfg_pst;
  // manual stop, or end of a single-shot post window
  assign stp_hit = ctl_stp || ((state == POST) && pst_end && !cfg_con);

  la_acq_counter #(
    .CW (CW)
  ) u_counter (
    .bus, .reset, .ctl_rst,
    .clr     (acq_start),
    .pre_inc, .pst_inc,
    .cts, .sts_pre, .sts_pst
  );

  ////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset || ctl_rst) begin
      state   <= IDLE;
      sts_trg <= 1'b0;
      sto_vld <= 1'b0;
    end else begin
      // output only while acquiring
      sto_vld <= std_vld && (state != IDLE);
      if (stp_hit) begin
        state <= IDLE;
      end else begin
        case (state)
          IDLE:  if (ctl_acq) state <= PRE;
          // cfg_pre of 0 arms right away
          PRE:   if (sts_pre == cfg_pre) state <= ARMED;
          ARMED: if (ctl_trg) state <= POST;
          default: ;
        endcase
      end
      if (acq_start) begin
        sts_trg <= 1'b0;
      end else if (trg_hit) begin
        sts_trg <= 1'b1;
      end
    end
  end

  // sample payload and event times
  always_ff @(posedge bus) begin
    sto_dat <= std_dat;
    if (acq_start) cts_acq <= cts;
    if (trg_hit) cts_trg <= cts;
    if (stp_hit) cts_stp <= cts;
  end

endmodule

// ==== logic/la_regset.sv ====
// System bus register set for the logic analyzer.
// Holds configuration, decodes control writes into single-cycle strobes,
// registers the read mux and ack, and merges the trigger sources.

`timescale 1ns/1ps

module la_regset import la_pkg::*; #(
  parameter int unsigned TN  = 4,
  parameter int unsigned CW  = $bits(count_t),
  parameter int unsigned DCW = $bits(dec_t)
) (
  input  logic            bus,
  input  logic            reset,
  // system bus
  input  bus_addr_t       bus_addr,
  input  bus_data_t       bus_wdata,
  input  logic            bus_wen,
  input  logic            bus_ren,
  output bus_data_t       bus_rdata,
  output logic            bus_ack,
  output logic            bus_err,
  // trigger sources
  input  logic [TN-1:0]   trg_ext,
  input  logic            trg_pat,
  output logic            trg_swo,
  // control strobes
  output logic            ctl_rst,
  output logic            ctl_acq,
  output logic            ctl_stp,
  output logic            ctl_trg,
  // configuration
  output logic            cfg_con,
  output logic [CW-1:0]   cfg_pre,
  output logic [CW-1:0]   cfg_pst,
  output logic [DCW-1:0]  cfg_dec,
  output sample_t         cfg_old_val,
  output sample_t         cfg_old_msk,
  output sample_t         cfg_cur_val,
  output sample_t         cfg_cur_msk,
  // status
  input  logic            sts_acq,
  input  logic            sts_trg,
  input  logic [CW-1:0]   sts_pre,
  input  logic [CW-1:0]   sts_pst,
  input  stamp_t          cts_acq,
  input  stamp_t          cts_trg,
  input  stamp_t          cts_stp
);

  // external trigger select
  logic [TN-1:0] cfg_trg;
  logic          ctl_wen;

  //////////////////////////////////////////////////////////////////////
  // control strobes
  //////////////////////////////////////////////////////////////////////

  // combinational, live only in the write cycle
  assign ctl_wen = bus_wen && (bus_addr == REG_CTL);
  assign ctl_rst = ctl_wen & bus_wdata[CTL_RST];
  assign ctl_acq = ctl_wen & bus_wdata[CTL_ACQ];
  assign ctl_stp = ctl_wen & bus_wdata[CTL_STP];
  assign trg_swo = ctl_wen & bus_wdata[CTL_SWT];

  // any selected external input, software or pattern match
  assign ctl_trg = |(trg_ext & cfg_trg) | trg_swo | trg_pat;

  // no error responses on this bus
  assign bus_err = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      bus_ack     <= 1'b0;
      cfg_con     <= 1'b0;
      cfg_trg     <= '0;
      cfg_pre     <= '0;
      cfg_pst     <= '0;
      cfg_dec     <= '0;
      cfg_old_val <= '0;
      cfg_old_msk <= '0;
      cfg_cur_val <= '0;
      cfg_cur_msk <= '0;
    end else begin
      // one-cycle response to either strobe
      bus_ack <= bus_wen | bus_ren;
      if (bus_wen) begin
        case (bus_addr)
          REG_CFG:     cfg_con     <= bus_wdata[0];
          REG_TRG_SEL: cfg_trg     <= bus_wdata[TN-1:0];
          REG_PRE:     cfg_pre     <= bus_wdata[CW-1:0];
          REG_PST:     cfg_pst     <= bus_wdata[CW-1:0];
          REG_OLD_VAL: cfg_old_val <= sample_t'(bus_wdata);
          REG_OLD_MSK: cfg_old_msk <= sample_t'(bus_wdata);
          REG_CUR_VAL: cfg_cur_val <= sample_t'(bus_wdata);
          REG_CUR_MSK: cfg_cur_msk <= sample_t'(bus_wdata);
          REG_DEC:     cfg_dec     <= bus_wdata[DCW-1:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////////////////////////

  // registered, lands together with ack
  always_ff @(posedge bus) begin
    case (bus_addr)
      // bit1 acquiring, bit2 idle, bit3 triggered
      REG_CTL:     bus_rdata <= bus_data_t'({sts_trg, ~sts_acq, sts_acq, 1'b0});
      REG_CFG:     bus_rdata <= bus_data_t'(cfg_con);
      REG_TRG_SEL: bus_rdata <= bus_data_t'(cfg_trg);
      REG_PRE:     bus_rdata <= bus_data_t'(cfg_pre);
      REG_PST:     bus_rdata <= bus_data_t'(cfg_pst);
      REG_STS_PRE: bus_rdata <= bus_data_t'(sts_pre);
      REG_STS_PST: bus_rdata <= bus_data_t'(sts_pst);
      REG_ACQ_LO:  bus_rdata <= cts_acq[31:0];
      REG_ACQ_HI:  bus_rdata <= cts_acq[63:32];
      REG_TRG_LO:  bus_rdata <= cts_trg[31:0];
      REG_TRG_HI:  bus_rdata <= cts_trg[63:32];
      REG_STP_LO:  bus_rdata <= cts_stp[31:0];
      REG_STP_HI:  bus_rdata <= cts_stp[63:32];
      REG_OLD_VAL: bus_rdata <= bus_data_t'(cfg_old_val);
      REG_OLD_MSK: bus_rdata <= bus_data_t'(cfg_old_msk);
      REG_CUR_VAL: bus_rdata <= bus_data_t'(cfg_cur_val);
      REG_CUR_MSK: bus_rdata <= bus_data_t'(cfg_cur_msk);
      REG_DEC:     bus_rdata <= bus_data_t'(cfg_dec);
      // unmapped reads as zero
      default:     bus_rdata <= '0;
    endcase
  end

endmodule

// ==== logic/la_top.sv ====
// Logic analyzer top level.
// Sample stream in, gated stream out, configured over the system bus.
// Holds only the register set, decimator, trigger and acquisition instances.

`timescale 1ns/1ps

module la_top import la_pkg::*; #(
  parameter int unsigned TN  = 4,               // external triggers
  parameter int unsigned CW  = $bits(count_t),  // window counter width
  parameter int unsigned DCW = $bits(dec_t)     // decimation counter width
) (
  input  logic            bus,
  input  logic            reset,
  // sample streams
  input  sample_t         sti_dat,
  input  logic            sti_vld,
  output sample_t         sto_dat,
  output logic            sto_vld,
  // triggers
  input  logic [TN-1:0]   trg_ext,
  output logic            trg_swo,
  output logic            trg_out,
  // system bus
  input  bus_addr_t       bus_addr,
  input  bus_data_t       bus_wdata,
  input  logic            bus_wen,
  input  logic            bus_ren,
  output bus_data_t       bus_rdata,
  output logic            bus_ack,
  output logic            bus_err
);

  // control strobes
  logic           ctl_rst;
  logic           ctl_acq;
  logic           ctl_stp;
  logic           ctl_trg;
  // configuration
  logic           cfg_con;
  logic [CW-1:0]  cfg_pre;
  logic [CW-1:0]  cfg_pst;
  logic [DCW-1:0] cfg_dec;
  sample_t        cfg_old_val;
  sample_t        cfg_old_msk;
  sample_t        cfg_cur_val;
  sample_t        cfg_cur_msk;
  // status back to the bus
  logic           sts_acq;
  logic           sts_trg;
  logic [CW-1:0]  sts_pre;
  logic [CW-1:0]  sts_pst;
  stamp_t         cts_acq;
  stamp_t         cts_trg;
  stamp_t         cts_stp;
  // decimated stream
  sample_t        std_dat;
  logic           std_vld;

  la_regset #(
    .TN  (TN),
    .CW  (CW),
    .DCW (DCW)
  ) u_regset (
    .bus, .reset,
    .bus_addr, .bus_wdata, .bus_wen, .bus_ren, .bus_rdata, .bus_ack, .bus_err,
    .trg_ext, .trg_pat (trg_out), .trg_swo,
    .ctl_rst, .ctl_acq, .ctl_stp, .ctl_trg,
    .cfg_con, .cfg_pre, .cfg_pst, .cfg_dec,
    .cfg_old_val, .cfg_old_msk, .cfg_cur_val, .cfg_cur_msk,
    .sts_acq, .sts_trg, .sts_pre, .sts_pst,
    .cts_acq, .cts_trg, .cts_stp
  );

  la_decimator #(
    .DCW (DCW)
  ) u_decimator (
    .bus, .reset, .ctl_rst, .cfg_dec,
    .sti_dat, .sti_vld, .std_dat, .std_vld
  );

  la_trigger u_trigger (
    .bus, .reset, .ctl_rst,
    .cfg_old_val, .cfg_old_msk, .cfg_cur_val, .cfg_cur_msk,
    .std_dat, .std_vld, .trg_out
  );

  la_acq_fsm #(
    .CW (CW)
  ) u_acq_fsm (
    .bus, .reset, .ctl_rst, .ctl_acq, .ctl_stp, .ctl_trg,
    .cfg_con, .cfg_pre, .cfg_pst,
    .std_dat, .std_vld, .sto_dat, .sto_vld,
    .sts_acq, .sts_trg, .sts_pre, .sts_pst,
    .cts_acq, .cts_trg, .cts_stp
  );

endmodule

// ==== testbench/la_asserts.sv ====
// Concurrent checks on the acquisition status and the bus response.
// Bound into the top level, where the FSM status and bus strobes meet.

`timescale 1ns/1ps

module la_asserts import la_pkg::*; #(
  parameter int unsigned CW = $bits(count_t)
) (
  input logic          bus,
  input logic          reset,
  input logic          sto_vld,
  input logic          sts_acq,
  input logic [CW-1:0] sts_pre,
  input logic [CW-1:0] cfg_pre,
  input logic          bus_wen,
  input logic          bus_ren,
  input logic          bus_ack
);

  // output beat only for a sample taken while acquiring
  a_no_idle_out: assert property (@(posedge bus) disable iff (reset)
    sto_vld |-> $past(sts_acq))
    else $error("sto_vld for a sample seen in IDLE");

  // pre counter saturates at the window size
  a_pre_limit: assert property (@(posedge bus) disable iff (reset)
    sts_acq |-> (sts_pre <= cfg_pre))
    else $error("sts_pre above cfg_pre");

  // ack exactly one cycle after each strobe
  a_ack_follows: assert property (@(posedge bus) disable iff (reset)
    (bus_wen || bus_ren) |=> bus_ack)
    else $error("missing ack after bus strobe");

  a_ack_cause: assert property (@(posedge bus) disable iff (reset)
    bus_ack |-> $past(bus_wen || bus_ren))
    else $error("ack without a bus strobe");

endmodule

bind la_top la_asserts #(
  .CW (CW)
) u_asserts (
  .bus, .reset, .sto_vld, .sts_acq, .sts_pre, .cfg_pre,
  .bus_wen, .bus_ren, .bus_ack
);

// ==== testbench/la_tb.sv ====
// Directed testbench for the logic analyzer.
// Drives the sample stream, external triggers and system bus of la_top and
// checks register readback, decimation, windows and every trigger source.

`timescale 1ns/1ps

module la_tb import la_pkg::*; ();

  localparam int TN  = 4;
  localparam int CW  = $bits(count_t);
  localparam int DCW = $bits(dec_t);
  // six tests of at most a few hundred cycles each, plus margin
  localparam int MAX_CYCLES = 4000;

  logic          bus = 1'b0;
  logic          reset;
  sample_t       sti_dat;
  logic          sti_vld;
  sample_t       sto_dat;
  logic          sto_vld;
  logic [TN-1:0] trg_ext;
  logic          trg_swo;
  logic          trg_out;
  bus_addr_t     bus_addr;
  bus_data_t     bus_wdata;
  logic          bus_wen;
  logic          bus_ren;
  bus_data_t     bus_rdata;
  logic          bus_ack;
  logic          bus_err;

  // monitor state
  int            cycles  = 0;
  int            out_cnt = 0;
  int            trg_cnt = 0;
  int            swo_cnt = 0;
  sample_t       out_q[$];
  sample_t       sent_q[$];

  la_top #(
    .TN  (TN),
    .CW  (CW),
    .DCW (DCW)
  ) uut (
    .bus, .reset, .sti_dat, .sti_vld, .sto_dat, .sto_vld,
    .trg_ext, .trg_swo, .trg_out,
    .bus_addr, .bus_wdata, .bus_wen, .bus_ren, .bus_rdata, .bus_ack, .bus_err
  );

  // 100 ns period
  always #50 bus = ~bus;

  //////////////////////////////////////////////////////////////////////
  // monitors and run limit
  //////////////////////////////////////////////////////////////////////

  // outputs settle well before the falling edge
  always @(negedge bus) begin
    if (!reset && sto_vld) begin
      out_cnt <= out_cnt + 1;
      out_q.push_back(sto_dat);
    end
    if (!reset && trg_out) begin
      trg_cnt <= trg_cnt + 1;
    end
    // software trigger strobe, live in the write cycle only
    if (!reset && trg_swo) begin
      swo_cnt <= swo_cnt + 1;
    end
  end

  always @(posedge bus) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      abort_run($sformatf("timeout, run exceeded %0d cycles", MAX_CYCLES));
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input bus_data_t got, input bus_data_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic bus_data_t field_mask(input int width);
    return (width >= 32) ? '1 : bus_data_t'((64'd1 << width) - 64'd1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // bus and stream drivers
  //////////////////////////////////////////////////////////////////////

  task automatic wait_ack();
    int spins;
    spins = 0;
    @(negedge bus);
    while (!bus_ack && spins < 4) begin
      @(negedge bus);
      spins++;
    end
    if (!bus_ack) abort_run("bus access got no ack");
    check("bus_err", {31'd0, bus_err}, 32'd0);
  endtask

  // single-cycle strobe, ack expected one cycle later
  task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
    @(posedge bus);
    bus_addr  <= addr;
    bus_wdata <= data;
    bus_wen   <= 1'b1;
    @(posedge bus);
    bus_wen <= 1'b0;
    wait_ack();
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
    @(posedge bus);
    bus_addr <= addr;
    bus_ren  <= 1'b1;
    @(posedge bus);
    bus_ren <= 1'b0;
    wait_ack();
    data = bus_rdata;
  endtask

  task automatic expect_reg(input string name, input bus_addr_t addr, input bus_data_t exp);
    bus_data_t data;
    bus_read(addr, data);
    check(name, data, exp);
  endtask

  task automatic ctl_write(input int bit_pos);
    bus_write(REG_CTL, 32'd1 << bit_pos);
  endtask

  task automatic configure(input bus_data_t con, input bus_data_t sel, input bus_data_t pre,
                           input bus_data_t pst, input bus_data_t dec);
    bus_write(REG_CFG, con);
    bus_write(REG_TRG_SEL, sel);
    bus_write(REG_PRE, pre);
    bus_write(REG_PST, pst);
    bus_write(REG_DEC, dec);
  endtask

  task automatic set_pattern(input sample_t ov, input sample_t om, input sample_t cv,
                             input sample_t cm);
    bus_write(REG_OLD_VAL, {24'd0, ov});
    bus_write(REG_OLD_MSK, {24'd0, om});
    bus_write(REG_CUR_VAL, {24'd0, cv});
    bus_write(REG_CUR_MSK, {24'd0, cm});
  endtask

  task automatic read_stamp(input bus_addr_t lo_addr, output stamp_t stamp);
    bus_data_t lo;
    bus_data_t hi;
    bus_read(lo_addr, lo);
    bus_read(lo_addr + 7'h4, hi);
    stamp = {hi, lo};
  endtask

  task automatic send_sample(input sample_t d);
    @(posedge bus);
    sti_dat <= d;
    sti_vld <= 1'b1;
  endtask

  task automatic stream_end();
    @(posedge bus);
    sti_vld <= 1'b0;
  endtask

  // back-to-back valid samples, logged for later compare
  task automatic send_random(input int n, input sample_t keep_mask);
    sample_t d;
    repeat (n) begin
      d = sample_t'($urandom()) & keep_mask;
      sent_q.push_back(d);
      send_sample(d);
    end
  endtask

  task automatic pulse_ext(input logic [TN-1:0] bits);
    @(posedge bus);
    trg_ext <= bits;
    @(posedge bus);
    trg_ext <= '0;
  endtask

  // wait for the output count, then make sure nothing else trails in
  task automatic wait_outputs(input int target);
    int spins;
    spins = 0;
    while (out_cnt < target && spins < 50) begin
      @(negedge bus);
      spins++;
    end
    if (out_cnt < target) abort_run("output stream stalled");
    repeat (4) @(negedge bus);
    check("sto_vld count", bus_data_t'(out_cnt), bus_data_t'(target));
  endtask

  task automatic wait_idle();
    bus_data_t sts;
    int polls;
    polls = 0;
    bus_read(REG_CTL, sts);
    while (sts[1] && polls < 20) begin
      bus_read(REG_CTL, sts);
      polls++;
    end
    if (sts[1]) abort_run("acquisition did not return to idle");
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic write_and_expect(input string name, input bus_addr_t addr,
                                  input bus_data_t data, input int width);
    bus_write(addr, data);
    expect_reg(name, addr, data & field_mask(width));
  endtask

  task automatic test_readback();
    write_and_expect("REG_CFG", REG_CFG, 32'hFFFF_FFF1, 1);
    write_and_expect("REG_TRG_SEL", REG_TRG_SEL, 32'hABCD_0009, TN);
    write_and_expect("REG_PRE", REG_PRE, 32'h1234_5678, CW);
    write_and_expect("REG_PST", REG_PST, 32'h8765_4321, CW);
    write_and_expect("REG_OLD_VAL", REG_OLD_VAL, 32'hA5A5_A511, $bits(sample_t));
    write_and_expect("REG_OLD_MSK", REG_OLD_MSK, 32'h0000_0F22, $bits(sample_t));
    write_and_expect("REG_CUR_VAL", REG_CUR_VAL, 32'h3333_3333, $bits(sample_t));
    write_and_expect("REG_CUR_MSK", REG_CUR_MSK, 32'hFFFF_FF44, $bits(sample_t));
    write_and_expect("REG_DEC", REG_DEC, 32'hFFFF_0F0F, DCW);
    // holes in the map
    expect_reg("unmapped 0x0c", 7'h0C, 32'h0);
    expect_reg("unmapped 0x60", 7'h60, 32'h0);
  endtask

  task automatic test_decimation();
    int base;
    int k;
    // continuous, no pre window, keep 1 of 4
    configure(32'h1, 32'h0, 32'h0, 32'h0, 32'h3);
    ctl_write(CTL_RST);
    ctl_write(CTL_ACQ);
    sent_q.delete();
    base = out_cnt;
    send_random(40, 8'hFF);
    stream_end();
    wait_outputs(base + 10);
    // every 4th input, i.e. samples 4, 8, 12 ...
    for (k = 0; k < 10; k++) begin
      check("sto_dat", {24'd0, out_q[base + k]}, {24'd0, sent_q[(k + 1) * 4 - 1]});
    end
    ctl_write(CTL_STP);
  endtask

  task automatic test_windows();
    int base;
    int sbase;
    stamp_t t_acq;
    stamp_t t_trg;
    stamp_t t_stp;
    sbase = swo_cnt;
    configure(32'h0, 32'h0, 32'd5, 32'd7, 32'h0);
    // data keeps bit7 clear so the pattern never fires
    set_pattern(8'h00, 8'h00, 8'h80, 8'h80);
    ctl_write(CTL_RST);
    ctl_write(CTL_ACQ);
    base = out_cnt;
    send_random(6, 8'h7F);
    stream_end();
    wait_outputs(base + 6);
    expect_reg("sts_pre", REG_STS_PRE, 32'd5);
    ctl_write(CTL_SWT);
    // one pulse for the trigger write, none for the writes before it
    check("trg_swo pulses", bus_data_t'(swo_cnt - sbase), 32'd1);
    base = out_cnt;
    send_random(10, 8'h7F);
    stream_end();
    wait_outputs(base + 7);
    // idle and triggered
    expect_reg("status", REG_CTL, 32'hC);
    expect_reg("sts_pre", REG_STS_PRE, 32'd5);
    expect_reg("sts_pst", REG_STS_PST, 32'd7);
    read_stamp(REG_ACQ_LO, t_acq);
    read_stamp(REG_TRG_LO, t_trg);
    read_stamp(REG_STP_LO, t_stp);
    check("cts_trg above cts_acq", {31'd0, t_trg > t_acq}, 32'd1);
    check("cts_stp above cts_trg", {31'd0, t_stp > t_trg}, 32'd1);
  endtask

  task automatic test_pattern();
    int base;
    int tbase;
    configure(32'h0, 32'h0, 32'd2, 32'd3, 32'h0);
    // 0x00 followed by 0xFF
    set_pattern(8'h00, 8'hFF, 8'hFF, 8'hFF);
    ctl_write(CTL_RST);
    ctl_write(CTL_ACQ);
    tbase = trg_cnt;
    base = out_cnt;
    // history is 0 after the reset, so the first 0xFF matches inside PRE
    send_sample(8'hFF);
    send_sample(8'h55);
    send_sample(8'h55);
    stream_end();
    wait_outputs(base + 3);
    check("trg_out pulses", bus_data_t'(trg_cnt - tbase), 32'd1);
    expect_reg("sts_pst", REG_STS_PST, 32'd0);
    expect_reg("status", REG_CTL, 32'h2);
    // real step while armed
    send_sample(8'h00);
    send_sample(8'hFF);
    repeat (6) send_sample(8'h11);
    stream_end();
    wait_idle();
    check("trg_out pulses", bus_data_t'(trg_cnt - tbase), 32'd2);
    expect_reg("sts_pst", REG_STS_PST, 32'd3);
    expect_reg("status", REG_CTL, 32'hC);
  endtask

  task automatic test_ext_trigger();
    // only input 1 selected, pattern kept out of reach
    configure(32'h0, 32'h2, 32'h0, 32'd2, 32'h0);
    set_pattern(8'h5A, 8'hFF, 8'hA5, 8'hFF);
    ctl_write(CTL_RST);
    ctl_write(CTL_ACQ);
    expect_reg("status", REG_CTL, 32'h2);
    pulse_ext(TN'(1));
    expect_reg("status", REG_CTL, 32'h2);
    pulse_ext(TN'(2));
    expect_reg("status", REG_CTL, 32'hA);
    repeat (3) send_sample(8'h00);
    stream_end();
    wait_idle();
    expect_reg("sts_pst", REG_STS_PST, 32'd2);
    expect_reg("status", REG_CTL, 32'hC);
  endtask

  task automatic test_stop();
    int base;
    configure(32'h0, 32'h0, 32'd10, 32'd4, 32'h0);
    ctl_write(CTL_RST);
    ctl_write(CTL_ACQ);
    base = out_cnt;
    send_random(3, 8'h7F);
    stream_end();
    wait_outputs(base + 3);
    // still filling the pre window
    ctl_write(CTL_STP);
    expect_reg("status", REG_CTL, 32'h4);
    base = out_cnt;
    send_random(5, 8'h7F);
    stream_end();
    wait_outputs(base);
  endtask

  initial begin
    void'($urandom(32'hb401));
    reset     = 1'b1;
    sti_dat   = '0;
    sti_vld   = 1'b0;
    trg_ext   = '0;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    repeat (3) @(posedge bus);
    reset <= 1'b0;
    test_readback();
    test_decimation();
    test_windows();
    test_pattern();
    test_ext_trigger();
    test_stop();
    $display("Test OK");
    $finish;
  end

endmodule

// ==== verilog.f ====
common/la_pkg.sv
logic/la_decimator.sv
logic/la_trigger.sv
acquire/la_acq_counter.sv
acquire/la_acq_fsm.sv
logic/la_regset.sv
logic/la_top.sv
testbench/la_asserts.sv
testbench/la_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := la_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert --Mdir $(OBJ_DIR)
LINT      := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
